// ==== common/upsp_pkg.sv ====
// Up-sampling write-back package with widths, image geometry, address steps and group views
package upsp_pkg;

	// Pixel and bus widths
	localparam int PIX_W  = 24;
	localparam int BEAT_W = 32;
	localparam int ADDR_W = 32;

	// One group is a kernel row of four pixels, sent as three beats
	localparam int PIX_PER_GROUP   = 4;
	localparam int BEATS_PER_BURST = 3;
	localparam int GROUP_W         = PIX_W * PIX_PER_GROUP;

	// One buffer per kernel row
	localparam int RING_DEPTH = 4;

	// Destination image geometry
	localparam int DST_IMG_WIDTH = 32;
	localparam int ROW_BYTES     = DST_IMG_WIDTH * (PIX_W / 8);

	// Kernel walk steps in bytes
	localparam int KERNEL_STEP      = GROUP_W / 8;
	localparam int KERNELS_PER_BAND = DST_IMG_WIDTH / PIX_PER_GROUP;
	// Next band starts four rows further down
	localparam int BAND_STEP        = ROW_BYTES * RING_DEPTH;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PIX_W-1:0]  pixel_t;
	typedef logic [BEAT_W-1:0] beat_t;

	// Ring index
	typedef logic [$clog2(RING_DEPTH)-1:0] slot_t;

	// One group word, seen as pixels by the packer and as beats by the writer
	// Element 0 sits in the lowest bits in both views
	typedef union packed {
		pixel_t [PIX_PER_GROUP-1:0]   pix;
		beat_t  [BEATS_PER_BURST-1:0] beat;
	} pix_group_u;

endpackage

// ==== verilog/pixel_packer.sv ====
// Pixel packer that gathers incoming pixels into ring slots in round-robin order
`timescale 1ns/1ps

module pixel_packer (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             pix_wr,
	input  upsp_pkg::pixel_t pix_data,
	output logic             pix_ready,
	input  logic             fill_free,
	output logic             fill_en,
	output upsp_pkg::slot_t  fill_slot,
	output logic [1:0]       fill_pixel_idx,
	output upsp_pkg::pixel_t fill_pixel
);

	upsp_pkg::slot_t slot_q;
	logic [1:0]      pix_idx_q;
	logic            last_pix;

	// Source waits while the slot still holds an undrained group
	assign pix_ready = fill_free;

	// Pixel accepted on wr and ready together
	assign fill_en = pix_wr & pix_ready;

	assign fill_slot      = slot_q;
	assign fill_pixel_idx = pix_idx_q;
	// Pixel goes straight into the slot
	assign fill_pixel     = pix_data;

	assign last_pix = (int'(pix_idx_q) == upsp_pkg::PIX_PER_GROUP - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_q    <= '0;
			pix_idx_q <= '0;
		end else if (fill_en) begin
			// Index wraps to 0 after the fourth pixel
			pix_idx_q <= pix_idx_q + 2'd1;
			// Complete group moves the fill to the next slot
			if (last_pix) begin
				slot_q <= slot_q + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/group_ring.sv ====
// Four-entry ring of group buffers with fill and drain valid bits
`timescale 1ns/1ps

module group_ring (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fill_en,
	input  upsp_pkg::slot_t      fill_slot,
	input  logic [1:0]           fill_pixel_idx,
	input  upsp_pkg::pixel_t     fill_pixel,
	output logic                 fill_free,
	input  logic                 drain_done,
	output logic                 head_valid,
	output upsp_pkg::pix_group_u head_group
);

	// Group storage
	upsp_pkg::pix_group_u ring_q [upsp_pkg::RING_DEPTH];

	logic [upsp_pkg::RING_DEPTH-1:0] valid_q;
	upsp_pkg::slot_t                 rd_ptr_q;
	logic                            fill_last;

	assign fill_last = fill_en &&
		(int'(fill_pixel_idx) == upsp_pkg::PIX_PER_GROUP - 1);

	// Slot under fill is free once its group has been drained
	assign fill_free = ~valid_q[fill_slot];

	// Head slot for the writer
	assign head_valid = valid_q[rd_ptr_q];
	assign head_group = ring_q[rd_ptr_q];

	// Pixel lands through the pixel view
	always_ff @(posedge clk) begin
		if (fill_en) begin
			ring_q[fill_slot].pix[fill_pixel_idx] <= fill_pixel;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q  <= '0;
			rd_ptr_q <= '0;
		end else begin
			// Fourth pixel makes the group visible on the next edge
			if (fill_last) begin
				valid_q[fill_slot] <= 1'b1;
			end
			// Last beat accepted, free the slot and step the head
			if (drain_done) begin
				valid_q[rd_ptr_q] <= 1'b0;
				rd_ptr_q          <= rd_ptr_q + 1'b1;
			end
		end
	end

	// Writer only drains groups that were completed
	assert property (@(posedge clk) disable iff (!rst_n)
		drain_done |-> valid_q[rd_ptr_q]);

	// Pixels never land in a group still waiting for the bus
	assert property (@(posedge clk) disable iff (!rst_n)
		fill_en |-> !valid_q[fill_slot]);

endmodule

// ==== verilog/axi_burst_writer.sv ====
// AXI4 write master sending each full group as a three-beat burst along the kernel walk
`timescale 1ns/1ps

module axi_burst_writer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 up_start,
	input  logic                 up_end,
	input  upsp_pkg::addr_t      dst_base,
	input  logic                 head_valid,
	input  upsp_pkg::pix_group_u head_group,
	output logic                 drain_done,
	output logic                 awvalid,
	output upsp_pkg::addr_t      awaddr,
	input  logic                 awready,
	output logic                 wvalid,
	output upsp_pkg::beat_t      wdata,
	output logic                 wlast,
	input  logic                 wready,
	input  logic                 bvalid,
	input  logic [1:0]           bresp,
	output logic                 bready
);

	// Burst FSM, one burst outstanding at most
	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_DATA,
		S_BWAIT,
		S_BACK
	} state_e;

	state_e state_q;

	logic processing_q;
	logic new_start;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic burst_open_q;

	logic [1:0] beat_cnt_q;

	// Kernel walk
	upsp_pkg::addr_t kern_addr_q;
	upsp_pkg::addr_t band_addr_q;
	upsp_pkg::addr_t row_offset;
	logic [1:0]      row_cnt_q;
	logic [$clog2(upsp_pkg::KERNELS_PER_BAND)-1:0] kern_col_q;

	assign new_start = up_start & ~up_end & ~processing_q;

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;
	assign b_hs  = bvalid & bready;

	// Channel outputs decoded from the state register
	assign awvalid = (state_q == S_ADDR);
	assign wvalid  = (state_q == S_DATA);
	assign bready  = (state_q == S_BACK);
	assign wlast   = wvalid && (int'(beat_cnt_q) == upsp_pkg::BEATS_PER_BURST - 1);

	// Beat picked through the beat view of the head group
	assign wdata = head_group.beat[beat_cnt_q];

	// Slot is released as the last beat goes out
	assign drain_done = w_hs & wlast;

	// Row offset inside the kernel
	assign row_offset = upsp_pkg::addr_t'(row_cnt_q) *
		upsp_pkg::addr_t'(upsp_pkg::ROW_BYTES);
	assign awaddr = kern_addr_q + row_offset;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing_q <= 1'b0;
		end else if (new_start) begin
			processing_q <= 1'b1;
		end else if (up_end & ~up_start) begin
			processing_q <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= S_IDLE;
			beat_cnt_q <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (head_valid) begin
						state_q <= S_ADDR;
					end
				end
				// Hold awvalid until the slave takes it
				S_ADDR: begin
					if (awready) begin
						state_q <= S_DATA;
					end
				end
				S_DATA: begin
					if (wready) begin
						if (wlast) begin
							beat_cnt_q <= '0;
							state_q    <= S_BWAIT;
						end else begin
							beat_cnt_q <= beat_cnt_q + 2'd1;
						end
					end
				end
				S_BWAIT: begin
					if (bvalid) begin
						state_q <= S_BACK;
					end
				end
				// One-cycle bready, burst closed
				S_BACK: begin
					state_q <= S_IDLE;
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

	// Address walk, steps on each AW handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kern_addr_q <= '0;
			band_addr_q <= '0;
			row_cnt_q   <= '0;
			kern_col_q  <= '0;
		end else if (new_start) begin
			kern_addr_q <= dst_base;
			band_addr_q <= dst_base;
			row_cnt_q   <= '0;
			kern_col_q  <= '0;
		end else if (aw_hs) begin
			row_cnt_q <= row_cnt_q + 2'd1;
			// Last row of the kernel done
			if (int'(row_cnt_q) == upsp_pkg::RING_DEPTH - 1) begin
				if (int'(kern_col_q) == upsp_pkg::KERNELS_PER_BAND - 1) begin
					// Right edge reached, down to the next band
					kern_col_q  <= '0;
					band_addr_q <= band_addr_q + upsp_pkg::addr_t'(upsp_pkg::BAND_STEP);
					kern_addr_q <= band_addr_q + upsp_pkg::addr_t'(upsp_pkg::BAND_STEP);
				end else begin
					kern_col_q  <= kern_col_q + 1'b1;
					kern_addr_q <= kern_addr_q + upsp_pkg::addr_t'(upsp_pkg::KERNEL_STEP);
				end
			end
		end
	end

	// Tracks AW to B span from the handshakes alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			burst_open_q <= 1'b0;
		end else if (aw_hs) begin
			burst_open_q <= 1'b1;
		end else if (b_hs) begin
			burst_open_q <= 1'b0;
		end
	end

	// No new address while a burst waits for its response
	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid |-> !burst_open_q);

	// Head group stays put until its last beat is out
	assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> head_valid);

	assert property (@(posedge clk) disable iff (!rst_n)
		beat_cnt_q < 2'd3);

	// Memory side expected to answer OKAY
	assert property (@(posedge clk) disable iff (!rst_n)
		b_hs |-> (bresp == 2'b00));

endmodule

// ==== verilog/upsp_writeback.sv ====
// Up-sampling write-back top joining the pixel packer, group ring and AXI burst writer
`timescale 1ns/1ps

module upsp_writeback (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             up_start,
	input  logic             up_end,
	input  upsp_pkg::addr_t  dst_base,
	input  logic             pix_wr,
	input  upsp_pkg::pixel_t pix_data,
	output logic             pix_ready,
	output logic             awvalid,
	output upsp_pkg::addr_t  awaddr,
	input  logic             awready,
	output logic             wvalid,
	output upsp_pkg::beat_t  wdata,
	output logic             wlast,
	input  logic             wready,
	input  logic             bvalid,
	input  logic [1:0]       bresp,
	output logic             bready
);

	// Packer to ring
	logic             fill_en;
	upsp_pkg::slot_t  fill_slot;
	logic [1:0]       fill_pixel_idx;
	upsp_pkg::pixel_t fill_pixel;
	logic             fill_free;

	// Ring to writer
	logic                 head_valid;
	upsp_pkg::pix_group_u head_group;
	logic                 drain_done;

	pixel_packer u_packer (
		.clk            (clk),
		.rst_n          (rst_n),
		.pix_wr         (pix_wr),
		.pix_data       (pix_data),
		.pix_ready      (pix_ready),
		.fill_free      (fill_free),
		.fill_en        (fill_en),
		.fill_slot      (fill_slot),
		.fill_pixel_idx (fill_pixel_idx),
		.fill_pixel     (fill_pixel)
	);

	group_ring u_ring (
		.clk            (clk),
		.rst_n          (rst_n),
		.fill_en        (fill_en),
		.fill_slot      (fill_slot),
		.fill_pixel_idx (fill_pixel_idx),
		.fill_pixel     (fill_pixel),
		.fill_free      (fill_free),
		.drain_done     (drain_done),
		.head_valid     (head_valid),
		.head_group     (head_group)
	);

	axi_burst_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.up_start   (up_start),
		.up_end     (up_end),
		.dst_base   (dst_base),
		.head_valid (head_valid),
		.head_group (head_group),
		.drain_done (drain_done),
		.awvalid    (awvalid),
		.awaddr     (awaddr),
		.awready    (awready),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wlast      (wlast),
		.wready     (wready),
		.bvalid     (bvalid),
		.bresp      (bresp),
		.bready     (bready)
	);

endmodule

// ==== bench/upsp_writeback_tb.sv ====
// Testbench for the up-sampling write-back block with case-file stimulus and an AXI slave model
`timescale 1ns/1ps

module upsp_writeback_tb;

	logic             clk;
	logic             rst_n    = 1'b0;
	logic             up_start = 1'b0;
	logic             up_end   = 1'b0;
	upsp_pkg::addr_t  dst_base = '0;
	logic             pix_wr   = 1'b0;
	upsp_pkg::pixel_t pix_data = '0;
	logic             pix_ready;
	logic             awvalid;
	upsp_pkg::addr_t  awaddr;
	logic             awready  = 1'b0;
	logic             wvalid;
	upsp_pkg::beat_t  wdata;
	logic             wlast;
	logic             wready   = 1'b0;
	logic             bvalid   = 1'b0;
	logic [1:0]       bresp    = 2'b00;
	logic             bready;

	// Case table from the file
	upsp_pkg::addr_t case_base [$];
	int              case_kern [$];
	int              case_stall [$];
	upsp_pkg::addr_t case_last [$];

	// Pixels sent but not yet seen on the W channel
	upsp_pkg::pixel_t exp_pix [$];

	integer seed       = 51;
	integer stall_seed = 51;
	int     cycles      = 0;
	int     cycle_limit = 0;

	// Current case
	upsp_pkg::addr_t cur_base   = '0;
	upsp_pkg::addr_t cur_last   = '0;
	int              cur_kern   = 0;
	int              cur_stall  = 0;
	int              case_first = 0;

	// Slave model and ring bookkeeping
	int aw_total    = 0;
	int bursts_done = 0;
	int burst_n     = 0;
	int beat_idx    = 0;
	int b_delay     = 0;
	bit b_pending   = 1'b0;
	bit burst_open  = 1'b0;
	bit saw_full    = 1'b0;
	int pix_cnt     = 0;
	int groups_in   = 0;
	int drained     = 0;
	logic [upsp_pkg::GROUP_W-1:0] exp_group = '0;

	upsp_writeback dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.up_start  (up_start),
		.up_end    (up_end),
		.dst_base  (dst_base),
		.pix_wr    (pix_wr),
		.pix_data  (pix_data),
		.pix_ready (pix_ready),
		.awvalid   (awvalid),
		.awaddr    (awaddr),
		.awready   (awready),
		.wvalid    (wvalid),
		.wdata     (wdata),
		.wlast     (wlast),
		.wready    (wready),
		.bvalid    (bvalid),
		.bresp     (bresp),
		.bready    (bready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_addr(input string name, input upsp_pkg::addr_t got,
		input upsp_pkg::addr_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_beat(input string name, input upsp_pkg::beat_t got,
		input upsp_pkg::beat_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Burst n is row n mod 4 of kernel n/4
	// New band after every eight kernels
	function automatic upsp_pkg::addr_t burst_addr(input upsp_pkg::addr_t base, input int n);
		int kern;
		int row;
		int offset;
		kern   = n / upsp_pkg::RING_DEPTH;
		row    = n % upsp_pkg::RING_DEPTH;
		offset = (kern / upsp_pkg::KERNELS_PER_BAND) * upsp_pkg::BAND_STEP +
			(kern % upsp_pkg::KERNELS_PER_BAND) * upsp_pkg::KERNEL_STEP +
			row * upsp_pkg::ROW_BYTES;
		return base + upsp_pkg::addr_t'(offset);
	endfunction

	task automatic check_idle_outputs();
		check_flag("awvalid", awvalid, 1'b0);
		check_flag("wvalid", wvalid, 1'b0);
		check_flag("wlast", wlast, 1'b0);
		check_flag("bready", bready, 1'b0);
		check_flag("pix_ready", pix_ready, 1'b1);
	endtask

	task automatic start_walk(input upsp_pkg::addr_t base);
		// End pulse first so the start counts as new
		@(posedge clk);
		up_end <= 1'b1;
		@(posedge clk);
		up_end   <= 1'b0;
		up_start <= 1'b1;
		dst_base <= base;
		@(posedge clk);
		up_start <= 1'b0;
	endtask

	task automatic send_pixels(input int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			exp_pix.push_back(rnd[upsp_pkg::PIX_W-1:0]);
			pix_wr   <= 1'b1;
			pix_data <= rnd[upsp_pkg::PIX_W-1:0];
			@(posedge clk);
			// Hold the pixel until the packer takes it
			while (!pix_ready) begin
				@(posedge clk);
			end
		end
		pix_wr <= 1'b0;
	endtask

	task automatic wait_bursts(input int target);
		while (bursts_done < target) begin
			@(posedge clk);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			report_failure("timeout, the bursts did not complete within the cycle limit");
		end
	end

	// AXI slave model, sampled on the rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			// Packer waits exactly when all four slots hold groups
			check_flag("pix_ready", pix_ready,
				(groups_in - drained) != upsp_pkg::RING_DEPTH);
			if (!pix_ready) begin
				saw_full = 1'b1;
			end
			if (pix_wr && pix_ready) begin
				pix_cnt++;
				if (pix_cnt % upsp_pkg::PIX_PER_GROUP == 0) begin
					groups_in++;
				end
			end
			if (awvalid && burst_open) begin
				report_failure("awvalid raised while a burst was still open");
			end
			if (awvalid && awready) begin
				burst_n = aw_total - case_first;
				check_addr("awaddr", awaddr, burst_addr(cur_base, burst_n));
				if (burst_n == cur_kern * upsp_pkg::RING_DEPTH - 1) begin
					check_addr("awaddr", awaddr, cur_last);
				end
				aw_total++;
				burst_open = 1'b1;
				beat_idx   = 0;
			end
			if (wvalid && !burst_open) begin
				report_failure("write data sent before its burst address");
			end
			if (wvalid && wready) begin
				if (beat_idx == 0) begin
					if (exp_pix.size() < upsp_pkg::PIX_PER_GROUP) begin
						report_failure("write data arrived with no pixels left to match");
					end
					// Pixel 0 in the lowest bits
					exp_group = {exp_pix[3], exp_pix[2], exp_pix[1], exp_pix[0]};
					repeat (upsp_pkg::PIX_PER_GROUP) begin
						void'(exp_pix.pop_front());
					end
				end
				check_beat("wdata", wdata,
					exp_group[beat_idx*upsp_pkg::BEAT_W +: upsp_pkg::BEAT_W]);
				check_flag("wlast", wlast, beat_idx == upsp_pkg::BEATS_PER_BURST - 1);
				beat_idx++;
				if (beat_idx == upsp_pkg::BEATS_PER_BURST) begin
					drained++;
					b_pending = 1'b1;
					b_delay   = (cur_stall != 0) ? ($random(stall_seed) & 3) : 0;
				end
			end
			if (bready && !bvalid) begin
				report_failure("bready raised with no write response pending");
			end
			// Response held until bready
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				burst_open = 1'b0;
				bursts_done++;
			end else if (b_pending) begin
				if (b_delay == 0) begin
					bvalid    <= 1'b1;
					bresp     <= 2'b00;
					b_pending = 1'b0;
				end else begin
					b_delay--;
				end
			end
			if (cur_stall != 0) begin
				awready <= ($random(stall_seed) & 1) != 0;
				wready  <= ($random(stall_seed) & 1) != 0;
			end else begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end
		end
	end

	initial begin
		int              fd;
		string           line;
		upsp_pkg::addr_t base;
		upsp_pkg::addr_t last;
		int              kern;
		int              stall;
		int              total_pix;
		total_pix = 0;
		fd = $fopen("bench/writeback_cases.txt", "r");
		if (fd == 0) begin
			report_failure("could not open bench/writeback_cases.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Header lines start with a hash
			if (line.len() > 0 && line.getc(0) != "#") begin
				if ($sscanf(line, "%h %d %d %h", base, kern, stall, last) == 4) begin
					case_base.push_back(base);
					case_kern.push_back(kern);
					case_stall.push_back(stall);
					case_last.push_back(last);
					total_pix += upsp_pkg::PIX_PER_GROUP * upsp_pkg::RING_DEPTH * kern;
				end
			end
		end
		$fclose(fd);
		if (case_base.size() == 0) begin
			report_failure("the cases file holds no cases");
		end
		cycle_limit = 20 * total_pix + 200;

		// Three cycles of reset with outputs checked at the falling edge
		@(posedge clk);
		@(negedge clk);
		check_idle_outputs();
		@(posedge clk);
		@(negedge clk);
		check_idle_outputs();
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle_outputs();
		@(posedge clk);

		foreach (case_base[i]) begin
			cur_base   = case_base[i];
			cur_kern   = case_kern[i];
			cur_stall  = case_stall[i];
			cur_last   = case_last[i];
			case_first = aw_total;
			start_walk(case_base[i]);
			send_pixels(cur_kern * upsp_pkg::PIX_PER_GROUP * upsp_pkg::RING_DEPTH);
			wait_bursts(case_first + cur_kern * upsp_pkg::RING_DEPTH);
			if (exp_pix.size() != 0) begin
				report_failure("pixels left over after the last burst of a case");
			end
		end

		if (!saw_full) begin
			report_failure("pix_ready never dropped although the ring should have filled");
		end else if (aw_total != total_pix / upsp_pkg::PIX_PER_GROUP) begin
			report_failure("burst count does not match the number of pixel groups");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== bench/writeback_cases.txt ====
# Columns: base address (hex), kernel count, stall mode (0 or 1),
# expected address of the last burst (hex)
00000000 1 0 00000120
00001000 2 0 0000112C
00002000 8 0 00002174
00003000 9 0 000032A0
00004000 3 1 00004138
00005000 10 1 000052AC
10000000 1 1 10000120
00000400 17 0 00000820
00006000 16 1 000062F4
0000A000 4 1 0000A144
80000000 2 0 8000012C
00007FF0 5 1 00008140
0000C000 12 0 0000C2C4
0000D000 1 0 0000D120
0000E000 8 1 0000E174
0000F000 6 1 0000F15C
00020000 24 1 00020474
00000100 2 1 0000022C

// ==== files.f ====
common/upsp_pkg.sv
verilog/pixel_packer.sv
verilog/group_ring.sv
verilog/axi_burst_writer.sv
verilog/upsp_writeback.sv
bench/upsp_writeback_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = upsp_writeback_tb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
